/* hdl/fifo_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIFO controller package
// Address, pointer and level widths shared by all controller blocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package fifo_pkg;

	// Storage address width for 32 entries
	localparam int ADDR_W = 5;

	// Pointer carries one extra wrap bit above the address
	localparam int PTR_W = ADDR_W + 1;

	localparam int FIFO_DEPTH = 32;

	// Storage address, also the width of the threshold inputs
	typedef logic [ADDR_W-1:0] addr_t;

	// Binary pointer or its Gray form
	typedef logic [PTR_W-1:0] ptr_t;

	// Occupancy or free count, 0 up to FIFO_DEPTH
	typedef logic [PTR_W-1:0] level_t;

endpackage

`default_nettype wire

/* hdl/ptr_sync.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pointer crossing
// Gray-encodes a pointer, optionally delays it, decodes it for the far side
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module ptr_sync import fifo_pkg::*; (
	input  logic rclk,
	input  logic rst_n,
	input  logic sync,
	input  ptr_t ptr_in,
	output ptr_t ptr_out
);

	ptr_t gray_in;
	ptr_t gray_q;
	ptr_t gray_d1;
	ptr_t gray_d2;
	ptr_t gray_sel;
	ptr_t bin_out;

	// Adjacent pointer values differ in one Gray bit
	assign gray_in = ptr_in ^ (ptr_in >> 1);

	// Source register, the only value that leaves the pointer's side
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			gray_q <= '0;
		end else begin
			gray_q <= gray_in;
		end
	end

	// Two synchroniser stages used when sync is low
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			gray_d1 <= '0;
			gray_d2 <= '0;
		end else begin
			gray_d1 <= gray_q;
			gray_d2 <= gray_d1;
		end
	end

	assign gray_sel = sync ? gray_q : gray_d2;

	// Each binary bit is the XOR of all Gray bits at and above it
	genvar i;
	generate
		for (i = 0; i < PTR_W; i++) begin : g_dec
			assign bin_out[i] = ^(gray_sel >> i);
		end
	endgenerate

	assign ptr_out = bin_out;

endmodule

`default_nettype wire

/* hdl/push_ctl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write side controller
// Holds the write pointer and registers full, almost full, paf, overflow
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module push_ctl import fifo_pkg::*; (
	input  logic  rclk,
	input  logic  rst_n,
	input  logic  wen,
	input  addr_t upaf,
	input  ptr_t  rptr_seen,
	output ptr_t  wptr,
	output addr_t waddr,
	output logic  full,
	output logic  afull,
	output logic  paf,
	output logic  overflow
);

	ptr_t   wptr_q;
	ptr_t   wptr_next;
	logic   push_ok;
	level_t count_next;
	level_t free_next;
	logic   full_q;
	logic   afull_q;
	logic   paf_q;
	logic   overflow_q;

	// A push while full is refused and leaves the pointer in place
	assign push_ok = wen & ~full_q;
	assign wptr_next = push_ok ? wptr_q + ptr_t'(1) : wptr_q;

	// The read pointer seen here lags, so the count can only be too high
	assign count_next = level_t'(wptr_next - rptr_seen);
	assign free_next = level_t'(FIFO_DEPTH) - count_next;

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			wptr_q <= '0;
		end else begin
			wptr_q <= wptr_next;
		end
	end

	// Level flags follow the next pointer, so they change at the push edge
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			full_q  <= 1'b0;
			afull_q <= 1'b0;
			paf_q   <= 1'b0;
		end else begin
			full_q  <= (count_next == level_t'(FIFO_DEPTH));
			afull_q <= (count_next == level_t'(FIFO_DEPTH - 1));
			paf_q   <= (free_next < {1'b0, upaf});
		end
	end

	// Overflow is rewritten on every write request, set only by a refused one
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			overflow_q <= 1'b0;
		end else if (wen) begin
			overflow_q <= full_q;
		end
	end

	assign wptr     = wptr_q;
	assign waddr    = wptr_q[ADDR_W-1:0];
	assign full     = full_q;
	assign afull    = afull_q;
	assign paf      = paf_q;
	assign overflow = overflow_q;

endmodule

`default_nettype wire

/* hdl/pop_ctl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read side controller
// Holds the read pointer and registers empty, almost empty, pae, underflow
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module pop_ctl import fifo_pkg::*; (
	input  logic  rclk,
	input  logic  rst_n,
	input  logic  ren,
	input  addr_t upae,
	input  ptr_t  wptr_seen,
	output ptr_t  rptr,
	output addr_t raddr,
	output logic  empty,
	output logic  aempty,
	output logic  pae,
	output logic  underflow
);

	ptr_t   rptr_q;
	ptr_t   rptr_next;
	logic   pop_ok;
	level_t count_next;
	logic   empty_q;
	logic   aempty_q;
	logic   pae_q;
	logic   underflow_q;

	// A pop while empty is refused and leaves the pointer in place
	assign pop_ok = ren & ~empty_q;
	assign rptr_next = pop_ok ? rptr_q + ptr_t'(1) : rptr_q;

	// The write pointer seen here lags, so the count can only be too low
	assign count_next = level_t'(wptr_seen - rptr_next);

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			rptr_q <= '0;
		end else begin
			rptr_q <= rptr_next;
		end
	end

	// An empty FIFO after reset also sits below any programmed threshold
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			empty_q  <= 1'b1;
			aempty_q <= 1'b0;
			pae_q    <= 1'b1;
		end else begin
			empty_q  <= (count_next == '0);
			aempty_q <= (count_next == level_t'(1));
			pae_q    <= (count_next < {1'b0, upae});
		end
	end

	// Underflow is rewritten on every read request, set only by a refused one
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			underflow_q <= 1'b0;
		end else if (ren) begin
			underflow_q <= empty_q;
		end
	end

	assign rptr      = rptr_q;
	assign raddr     = rptr_q[ADDR_W-1:0];
	assign empty     = empty_q;
	assign aempty    = aempty_q;
	assign pae       = pae_q;
	assign underflow = underflow_q;

endmodule

`default_nettype wire

/* hdl/fifo_ctl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIFO controller top level
// Two side controllers joined by a Gray pointer crossing in each direction
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fifo_ctl import fifo_pkg::*; (
	input  logic  rclk,
	input  logic  rst_n,
	input  logic  sync,
	input  logic  wen,
	input  logic  ren,
	input  addr_t upaf,
	input  addr_t upae,
	output addr_t waddr,
	output addr_t raddr,
	output logic  full,
	output logic  afull,
	output logic  paf,
	output logic  overflow,
	output logic  empty,
	output logic  aempty,
	output logic  pae,
	output logic  underflow
);

	ptr_t wptr;
	ptr_t rptr;
	ptr_t wptr_seen;
	ptr_t rptr_seen;

	push_ctl i_push_ctl (
		.rclk      (rclk),
		.rst_n     (rst_n),
		.wen       (wen),
		.upaf      (upaf),
		.rptr_seen (rptr_seen),
		.wptr      (wptr),
		.waddr     (waddr),
		.full      (full),
		.afull     (afull),
		.paf       (paf),
		.overflow  (overflow)
	);

	pop_ctl i_pop_ctl (
		.rclk      (rclk),
		.rst_n     (rst_n),
		.ren       (ren),
		.upae      (upae),
		.wptr_seen (wptr_seen),
		.rptr      (rptr),
		.raddr     (raddr),
		.empty     (empty),
		.aempty    (aempty),
		.pae       (pae),
		.underflow (underflow)
	);

	// Write pointer towards the read side
	ptr_sync i_wptr_sync (
		.rclk    (rclk),
		.rst_n   (rst_n),
		.sync    (sync),
		.ptr_in  (wptr),
		.ptr_out (wptr_seen)
	);

	// Read pointer towards the write side
	ptr_sync i_rptr_sync (
		.rclk    (rclk),
		.rst_n   (rst_n),
		.sync    (sync),
		.ptr_in  (rptr),
		.ptr_out (rptr_seen)
	);

endmodule

`default_nettype wire

/* bench/fifo_ctl_chk.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIFO controller flag assertions, bound into the controller top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fifo_ctl_chk (
	input logic rclk,
	input logic rst_n,
	input logic full,
	input logic afull,
	input logic empty,
	input logic aempty
);

	// Number of assertion failures so far
	int unsigned fail_count = 0;

	// A FIFO of 32 entries cannot be full and empty at once
	a_full_empty: assert property (@(posedge rclk) disable iff (!rst_n) !(full && empty))
		else begin
			fail_count++;
			$error("full and empty are high together");
		end

	// The two sides disagree by only a few entries while pointers cross
	a_afull: assert property (@(posedge rclk) disable iff (!rst_n) afull |-> !empty)
		else begin
			fail_count++;
			$error("afull is high together with empty");
		end

	a_aempty: assert property (@(posedge rclk) disable iff (!rst_n) aempty |-> !full)
		else begin
			fail_count++;
			$error("aempty is high together with full");
		end

endmodule

bind fifo_ctl fifo_ctl_chk i_fifo_ctl_chk (
	.rclk   (rclk),
	.rst_n  (rst_n),
	.full   (full),
	.afull  (afull),
	.empty  (empty),
	.aempty (aempty)
);

`default_nettype wire

/* bench/tb_fifo_ctl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIFO controller testbench
// LFSR driven pushes and pops checked against an occupancy model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_fifo_ctl import fifo_pkg::*; ();

	logic  rclk;
	logic  rst_n;
	logic  sync;
	logic  wen;
	logic  ren;
	addr_t upaf;
	addr_t upae;
	addr_t waddr;
	addr_t raddr;
	logic  full;
	logic  afull;
	logic  paf;
	logic  overflow;
	logic  empty;
	logic  aempty;
	logic  pae;
	logic  underflow;

	// Model state, updated when a request is accepted
	int    count;
	ptr_t  m_wptr;
	ptr_t  m_rptr;
	logic  exp_overflow;
	logic  exp_underflow;
	addr_t cur_upaf;
	addr_t cur_upae;
	logic [15:0] lfsr;

	fifo_ctl i_fifo_ctl (
		.rclk      (rclk),
		.rst_n     (rst_n),
		.sync      (sync),
		.wen       (wen),
		.ren       (ren),
		.upaf      (upaf),
		.upae      (upae),
		.waddr     (waddr),
		.raddr     (raddr),
		.full      (full),
		.afull     (afull),
		.paf       (paf),
		.overflow  (overflow),
		.empty     (empty),
		.aempty    (aempty),
		.pae       (pae),
		.underflow (underflow)
	);

	initial begin
		rclk = 1'b0;
		forever #2 rclk = ~rclk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			abort_run($sformatf("CHECK FAILED: %s got 0x%0h, expected 0x%0h at %0t",
				name, got, expected, $time));
		end
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	// One clock: check what the last edge did, then drive the next request
	task automatic cycle(input logic w, input logic r, input addr_t pf, input addr_t pe);
		@(negedge rclk);
		check_value("waddr", 32'(waddr), 32'(m_wptr[ADDR_W-1:0]));
		check_value("raddr", 32'(raddr), 32'(m_rptr[ADDR_W-1:0]));
		check_value("overflow", 32'(overflow), 32'(exp_overflow));
		check_value("underflow", 32'(underflow), 32'(exp_underflow));
		if (count == FIFO_DEPTH) begin
			check_value("full", 32'(full), 32'(1));
		end
		if (count == 0) begin
			check_value("empty", 32'(empty), 32'(1));
		end
		if (w) begin
			exp_overflow = full;
			if (!full) begin
				m_wptr = m_wptr + ptr_t'(1);
				count = count + 1;
			end
		end
		if (r) begin
			exp_underflow = empty;
			if (!empty) begin
				m_rptr = m_rptr + ptr_t'(1);
				count = count - 1;
			end
		end
		wen = w;
		ren = r;
		upaf = pf;
		upae = pe;
	endtask

	task automatic idle(input int n);
		repeat (n) cycle(1'b0, 1'b0, cur_upaf, cur_upae);
	endtask

	// Flags are compared once the crossing has settled
	task automatic check_levels();
		cycle(1'b0, 1'b0, cur_upaf, cur_upae);
		check_value("full", 32'(full), 32'(count == FIFO_DEPTH));
		check_value("afull", 32'(afull), 32'(count == FIFO_DEPTH - 1));
		check_value("paf", 32'(paf), 32'((FIFO_DEPTH - count) < int'(cur_upaf)));
		check_value("empty", 32'(empty), 32'(count == 0));
		check_value("aempty", 32'(aempty), 32'(count == 1));
		check_value("pae", 32'(pae), 32'(count < int'(cur_upae)));
	endtask

	task automatic move_to_level(input int target);
		int guard;
		guard = 0;
		while (count != target && guard < 200) begin
			cycle(count < target, count > target, cur_upaf, cur_upae);
			guard++;
		end
		if (count != target) begin
			abort_run($sformatf("occupancy stuck at %0d while heading for %0d",
				count, target));
		end
	endtask

	task automatic check_reset();
		check_value("waddr", 32'(waddr), 32'(0));
		check_value("raddr", 32'(raddr), 32'(0));
		check_value("full", 32'(full), 32'(0));
		check_value("afull", 32'(afull), 32'(0));
		check_value("paf", 32'(paf), 32'(0));
		check_value("overflow", 32'(overflow), 32'(0));
		check_value("empty", 32'(empty), 32'(1));
		check_value("aempty", 32'(aempty), 32'(0));
		check_value("pae", 32'(pae), 32'(1));
		check_value("underflow", 32'(underflow), 32'(0));
	endtask

	task automatic random_bursts(input int bursts);
		int v;
		int bias;
		int len;
		int pw;
		int pr;
		for (int b = 0; b < bursts; b++) begin
			draw_bits(5, v);
			cur_upaf = addr_t'(v);
			draw_bits(5, v);
			cur_upae = addr_t'(v);
			// Bias 0 mostly drains, bias 3 mostly fills
			draw_bits(2, bias);
			draw_bits(5, len);
			for (int i = 0; i < 4 + len; i++) begin
				draw_bits(2, pw);
				draw_bits(2, pr);
				cycle(pw <= bias, pr >= bias, cur_upaf, cur_upae);
			end
			idle(4);
			check_levels();
		end
	endtask

	task automatic fill_and_overflow();
		addr_t hold;
		move_to_level(FIFO_DEPTH);
		cycle(1'b0, 1'b0, cur_upaf, cur_upae);
		check_value("full", 32'(full), 32'(1));
		hold = m_wptr[ADDR_W-1:0];
		repeat (3) cycle(1'b1, 1'b0, cur_upaf, cur_upae);
		cycle(1'b0, 1'b0, cur_upaf, cur_upae);
		check_value("waddr", 32'(waddr), 32'(hold));
		check_value("overflow", 32'(overflow), 32'(1));
		cycle(1'b0, 1'b1, cur_upaf, cur_upae);
		idle(4);
		cycle(1'b1, 1'b0, cur_upaf, cur_upae);
		cycle(1'b0, 1'b0, cur_upaf, cur_upae);
		check_value("overflow", 32'(overflow), 32'(0));
	endtask

	task automatic drain_and_underflow();
		addr_t hold;
		move_to_level(0);
		cycle(1'b0, 1'b0, cur_upaf, cur_upae);
		check_value("empty", 32'(empty), 32'(1));
		hold = m_rptr[ADDR_W-1:0];
		repeat (3) cycle(1'b0, 1'b1, cur_upaf, cur_upae);
		cycle(1'b0, 1'b0, cur_upaf, cur_upae);
		check_value("raddr", 32'(raddr), 32'(hold));
		check_value("underflow", 32'(underflow), 32'(1));
		cycle(1'b1, 1'b0, cur_upaf, cur_upae);
		idle(4);
		cycle(1'b0, 1'b1, cur_upaf, cur_upae);
		cycle(1'b0, 1'b0, cur_upaf, cur_upae);
		check_value("underflow", 32'(underflow), 32'(0));
	endtask

	task automatic sweep_thresholds();
		int levels [5] = '{0, 1, 16, FIFO_DEPTH - 1, FIFO_DEPTH};
		for (int k = 0; k < 5; k++) begin
			move_to_level(levels[k]);
			idle(4);
			for (int t = 0; t < FIFO_DEPTH; t++) begin
				cur_upaf = addr_t'(t);
				cur_upae = addr_t'(FIFO_DEPTH - 1 - t);
				cycle(1'b0, 1'b0, cur_upaf, cur_upae);
				check_levels();
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		sync = 1'b1;
		wen = 1'b0;
		ren = 1'b0;
		upaf = '0;
		upae = '0;
		count = 0;
		m_wptr = '0;
		m_rptr = '0;
		exp_overflow = 1'b0;
		exp_underflow = 1'b0;
		cur_upaf = '0;
		cur_upae = '0;
		lfsr = 16'd24;
		repeat (3) @(negedge rclk);
		check_reset();
		rst_n = 1'b1;
		random_bursts(40);
		fill_and_overflow();
		drain_and_underflow();
		sweep_thresholds();
		// Switch to the three cycle crossing while nothing is in flight
		idle(4);
		sync = 1'b0;
		random_bursts(40);
		if (i_fifo_ctl.i_fifo_ctl_chk.fail_count != 0) begin
			abort_run("a flag assertion failed during the run");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* list.f */
hdl/fifo_pkg.sv
hdl/ptr_sync.sv
hdl/push_ctl.sv
hdl/pop_ctl.sv
hdl/fifo_ctl.sv
bench/fifo_ctl_chk.sv
bench/tb_fifo_ctl.sv

/* Makefile */
TOP := tb_fifo_ctl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f list.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir
